//--- sources.f
+incdir+.
sprite_pkg.sv
vga_ifs.sv
vga_timing.sv
sprite_store.sv
color_palette.sv
sprite_renderer.sv
vga_sprite_engine.sv
vga_sprite_asserts.sv
tb_vga_sprite_engine.sv

//--- Makefile
TOP = tb_vga_sprite_engine

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 -f sources.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

//--- tb_vga_sprite_engine.sv
// Module tb_vga_sprite_engine, clock, reset, write table, reference model, probes and report
`timescale 1ns/1ps
`include "sprite_defs.svh"

module tb_vga_sprite_engine;

    import sprite_pkg::*;

    localparam int FRAME = `HTOTAL * `VTOTAL;
    localparam int NTESTS = 6;
    localparam int NPROBES = 20;

    logic clk, reset, chipselect, write;
    logic [`ADDR_W-1:0] address;
    logic [31:0] writedata;
    logic [7:0] vga_r, vga_g, vga_b;
    logic vga_clk, vga_hs, vga_vs, vga_blank_n, vga_sync_n;

    int seed = 32'h9556d81e;
    int wr_addr [$];
    logic [31:0] wr_data [$];
    // Each probe holds pixel column, line and test number
    int probe_tab [NPROBES][3] = '{
        '{20, 10, 3}, '{35, 25, 3}, '{27, 17, 3}, '{19, 12, 3}, '{36, 12, 3},
        '{25, 9, 3}, '{25, 26, 3}, '{105, 55, 4}, '{200, 100, 4}, '{204, 103, 4},
        '{201, 100, 4}, '{310, 210, 5}, '{315, 215, 5}, '{302, 202, 5}, '{0, 0, 5},
        '{308, 208, 6}, '{309, 208, 6}, '{310, 208, 6}, '{311, 208, 6}, '{312, 209, 6}
    };
    int checks [1:NTESTS];
    int errors [1:NTESTS];

    // Reference model state
    rgb_t m_bg;
    int m_x [`MAX_OBJECTS], m_y [`MAX_OBJECTS], m_spr [`MAX_OBJECTS];
    bit m_act [`MAX_OBJECTS];
    logic [7:0] m_pat [1024];

    vga_sprite_engine vga_sprite_engine_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #((longint'(3) * FRAME + 16) * 10);
        $display("Watchdog expired before the frame checks completed");
        $display("Result: FAILED");
        $finish;
    end

    function automatic rgb_t palette(input int idx);
        int k;
        if (idx < 216) begin
            return {8'((idx / 36) * 51), 8'(((idx / 6) % 6) * 51), 8'((idx % 6) * 51)};
        end
        k = idx - 216;
        return {8'(k * 47), 8'(k * 91), 8'(k * 137)};
    endfunction

    function automatic rgb_t expected_pixel(input int h, input int v);
        int px, dx, dy, idx;
        bit hit;
        px = h / 2;
        hit = 0;
        idx = 0;
        if (h >= `HACTIVE || v >= `VACTIVE) begin
            return 24'h0;
        end
        for (int i = 0; i < `MAX_OBJECTS; i++) begin
            dx = px - m_x[i];
            dy = v - m_y[i];
            if (m_act[i] && dx >= 0 && dx < `SPRITE_SIZE &&
                dy >= 0 && dy < `SPRITE_SIZE) begin
                hit = 1;
                idx = int'(m_pat[m_spr[i] * 256 + dy * 16 + dx]);
            end
        end
        return (hit && idx != 0) ? palette(idx) : m_bg;
    endfunction

    task automatic add_object(input int n, input int x, input int y, input int spr, input bit act);
        wr_addr.push_back(`ADDR_OBJ_BASE + n);
        wr_data.push_back({12'(x), 12'(y), 3'b000, 2'(spr), act, 2'b00});
    endtask

    task automatic model_write(input int a, input logic [31:0] d);
        if (a == `ADDR_BG) begin
            m_bg = d[23:0];
        end else if (a >= `ADDR_OBJ_BASE && a < `ADDR_OBJ_BASE + `MAX_OBJECTS) begin
            m_x[a - 1] = int'(d[31:20]);
            m_y[a - 1] = int'(d[19:8]);
            m_spr[a - 1] = int'(d[4:3]);
            m_act[a - 1] = d[2];
        end else if (a >= `ADDR_PAT_BASE) begin
            for (int k = 0; k < 4; k++) begin
                m_pat[(a - `ADDR_PAT_BASE) * 4 + k] = d[8*k +: 8];
            end
        end
    endtask

    initial begin
        logic [31:0] w;
        rgb_t exp_rgb;
        int pos, h, v, cyc;
        int total_checks, total_errors;
        bit ok;
        reset = 1'b1;
        chipselect = 1'b0;
        write = 1'b0;
        address = '0;
        writedata = '0;
        m_bg = `BG_RESET;
        for (int i = 0; i < `MAX_OBJECTS; i++) begin
            m_act[i] = 0;
        end
        for (int t = 1; t <= NTESTS; t++) begin
            checks[t] = 0;
            errors[t] = 0;
        end
        for (int n = 0; n < 256; n++) begin
            w = $random(seed);
            // Sprite 1 has a transparent column every fourth pixel
            if (n >= 64 && n < 128) begin
                w[7:0] = 8'h00;
            end
            // Sprite 3 row 0 holds 215, 216, 255 and 1
            if (n == 192) begin
                w = 32'h01FFD8D7;
            end
            wr_addr.push_back(`ADDR_PAT_BASE + n);
            wr_data.push_back(w);
        end
        add_object(0, 20, 10, 0, 1);
        add_object(1, 100, 50, 2, 0);
        add_object(2, 200, 100, 1, 1);
        add_object(3, 300, 200, 2, 1);
        add_object(5, 308, 208, 3, 1);
        wr_addr.push_back(100);
        wr_data.push_back(32'hFFFF_FFFC);

        repeat (16) @(negedge clk);
        reset = 1'b0;
        cyc = 0;
        foreach (wr_addr[i]) begin
            chipselect = 1'b1;
            write = 1'b1;
            address = `ADDR_W'(wr_addr[i]);
            writedata = wr_data[i];
            model_write(wr_addr[i], wr_data[i]);
            @(negedge clk);
            cyc++;
        end
        chipselect = 1'b0;
        write = 1'b0;

        // Outputs at this edge reflect the counter three cycles earlier
        while (cyc < 2 * FRAME + 3) begin
            @(negedge clk);
            cyc++;
            pos = cyc - 3;
            if (pos >= FRAME) begin
                h = pos % `HTOTAL;
                v = (pos / `HTOTAL) % `VTOTAL;
                exp_rgb = expected_pixel(h, v);
                checks[1]++;
                assert ({vga_r, vga_g, vga_b} == exp_rgb) else begin
                    $display("error: %0t pixel h=%0d v=%0d got %h expected %h",
                             $time, h, v, {vga_r, vga_g, vga_b}, exp_rgb);
                    errors[1]++;
                end
                ok = (vga_hs == !(h >= `HSYNC_START && h < `HSYNC_START + `HSYNC_LEN)) &&
                     (vga_vs == !(v >= `VSYNC_START && v < `VSYNC_START + `VSYNC_LEN)) &&
                     (vga_blank_n == (h < `HACTIVE && v < `VACTIVE)) &&
                     (vga_clk == h[0]) && !vga_sync_n;
                checks[2]++;
                assert (ok) else begin
                    $display("error: %0t sync h=%0d v=%0d hs=%b vs=%b blank_n=%b clk=%b",
                             $time, h, v, vga_hs, vga_vs, vga_blank_n, vga_clk);
                    errors[2]++;
                end
                foreach (probe_tab[p]) begin
                    if (h == 2 * probe_tab[p][0] && v == probe_tab[p][1]) begin
                        checks[probe_tab[p][2]]++;
                        assert ({vga_r, vga_g, vga_b} == exp_rgb) else begin
                            $display("error: %0t probe col=%0d line=%0d got %h expected %h",
                                     $time, probe_tab[p][0], v, {vga_r, vga_g, vga_b}, exp_rgb);
                            errors[probe_tab[p][2]]++;
                        end
                    end
                end
            end
        end

        for (int t = 1; t <= NTESTS; t++) begin
            $display("test %0d: %0d checks, %0d errors", t, checks[t], errors[t]);
        end
        total_checks = 0;
        total_errors = 0;
        for (int t = 1; t <= NTESTS; t++) begin
            total_checks += checks[t];
            total_errors += errors[t];
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- vga_sprite_asserts.sv
// Module vga_sprite_asserts, concurrent checks on the VGA outputs, and its bind
`timescale 1ns/1ps
`include "sprite_defs.svh"

module vga_sprite_asserts (
    input logic       clk,
    input logic       reset,
    input logic [7:0] vga_r,
    input logic [7:0] vga_g,
    input logic [7:0] vga_b,
    input logic       vga_clk,
    input logic       vga_hs,
    input logic       vga_blank_n
);

    logic [3:0]  settle;
    logic [10:0] low_len;

    // Delay line needs a few cycles before vga_clk toggles
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            settle  <= '0;
            low_len <= '0;
        end else begin
            if (settle != 4'd8) begin
                settle <= settle + 4'd1;
            end
            low_len <= vga_hs ? 11'd0 : low_len + 11'd1;
        end
    end

    blank_black: assert property (@(posedge clk) disable iff (reset)
        !vga_blank_n |-> ({vga_r, vga_g, vga_b} == 24'h0))
        else $error("RGB not black during blanking");

    clk_toggle: assert property (@(posedge clk) disable iff (reset || settle != 4'd8)
        vga_clk != $past(vga_clk))
        else $error("vga_clk did not toggle");

    hs_width: assert property (@(posedge clk) disable iff (reset)
        $rose(vga_hs) |-> (low_len == 11'(`HSYNC_LEN)))
        else $error("vga_hs low pulse has wrong length");

endmodule

bind vga_sprite_engine vga_sprite_asserts vga_sprite_asserts_i (.*);

//--- vga_sprite_engine.sv
// Module vga_sprite_engine, top level joining scan timing, register store and renderer
`timescale 1ns/1ps
`include "sprite_defs.svh"

module vga_sprite_engine (
    input  logic               clk,
    input  logic               reset,
    input  logic               chipselect,
    input  logic               write,
    input  logic [`ADDR_W-1:0] address,
    input  logic [31:0]        writedata,
    output logic [7:0]         vga_r,
    output logic [7:0]         vga_g,
    output logic [7:0]         vga_b,
    output logic               vga_clk,
    output logic               vga_hs,
    output logic               vga_vs,
    output logic               vga_blank_n,
    output logic               vga_sync_n
);

    import sprite_pkg::*;

    rgb_t pixel;

    scan_if       scan ();
    sprite_bus_if sprite_bus ();

    vga_timing vga_timing_i (
        .clk   (clk),
        .reset (reset),
        .scan  (scan)
    );

    sprite_store sprite_store_i (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .bus        (sprite_bus)
    );

    sprite_renderer sprite_renderer_i (
        .clk     (clk),
        .reset   (reset),
        .scan    (scan),
        .bus     (sprite_bus),
        .rgb     (pixel),
        .hsync   (vga_hs),
        .vsync   (vga_vs),
        .blank_n (vga_blank_n),
        .pix_clk (vga_clk)
    );

    assign vga_r = pixel.r;
    assign vga_g = pixel.g;
    assign vga_b = pixel.b;

    // No sync on green
    assign vga_sync_n = 1'b0;

endmodule

//--- sprite_renderer.sv
// Module sprite_renderer, object match, pattern read, palette lookup, mixing and sync delay
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_renderer (
    input  logic             clk,
    input  logic             reset,
    scan_if.sink             scan,
    sprite_bus_if.renderer   bus,
    output sprite_pkg::rgb_t rgb,
    output logic             hsync,
    output logic             vsync,
    output logic             blank_n,
    output logic             pix_clk
);

    import sprite_pkg::*;

    logic [9:0]  px;
    logic [12:0] dx;
    logic [12:0] dy;
    logic        hit;
    logic [9:0]  addr;
    logic        hit_q1;
    logic        hit_q2;
    logic        show_q3;
    rgb_t        bg_q1;
    rgb_t        bg_q2;
    rgb_t        bg_q3;
    rgb_t        sprite_rgb;
    logic [2:0]  hs_d;
    logic [2:0]  vs_d;
    logic [2:0]  blank_d;
    logic [2:0]  clk_d;

    // Pixel column from the double-rate counter
    assign px = scan.hcount[10:1];

    // Stage 1 match, the highest index wins
    always_comb begin
        hit  = 1'b0;
        addr = '0;
        dx   = '0;
        dy   = '0;
        for (int i = 0; i < `MAX_OBJECTS; i++) begin
            // Negative offsets wrap to large values and fail the range test
            dx = 13'(px) - 13'(bus.objects[i].x);
            dy = 13'(scan.vcount) - 13'(bus.objects[i].y);
            if (bus.objects[i].active && dx < 13'(`SPRITE_SIZE) &&
                dy < 13'(`SPRITE_SIZE)) begin
                hit  = 1'b1;
                addr = 10'(bus.objects[i].sprite * (`SPRITE_SIZE * `SPRITE_SIZE) +
                           dy * `SPRITE_SIZE + dx);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hit_q1  <= 1'b0;
            hit_q2  <= 1'b0;
            show_q3 <= 1'b0;
        end else begin
            hit_q1  <= hit;
            hit_q2  <= hit_q1;
            // Index 0 is transparent
            show_q3 <= hit_q2 && (bus.pat_data != '0);
        end
    end

    always_ff @(posedge clk) begin
        bus.pat_addr <= addr;
        bg_q1        <= bus.background;
        bg_q2        <= bg_q1;
        bg_q3        <= bg_q2;
    end

    // Stage 3 palette register
    color_palette color_palette_i (
        .clk   (clk),
        .index (bus.pat_data),
        .color (sprite_rgb)
    );

    // Sync and blank delayed to match the pixel path
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hs_d    <= 3'b111;
            vs_d    <= 3'b111;
            blank_d <= 3'b000;
            clk_d   <= 3'b000;
        end else begin
            hs_d    <= {hs_d[1:0], scan.hsync};
            vs_d    <= {vs_d[1:0], scan.vsync};
            blank_d <= {blank_d[1:0], scan.blank_n};
            clk_d   <= {clk_d[1:0], scan.pix_clk};
        end
    end

    assign hsync   = hs_d[2];
    assign vsync   = vs_d[2];
    assign blank_n = blank_d[2];
    assign pix_clk = clk_d[2];

    // Black outside the active area
    assign rgb = !blank_d[2] ? '0 : (show_q3 ? sprite_rgb : bg_q3);

endmodule

//--- color_palette.sv
// Module color_palette, registered colour index to RGB conversion
`timescale 1ns/1ps

module color_palette (
    input  logic                     clk,
    input  sprite_pkg::pixel_index_t index,
    output sprite_pkg::rgb_t         color
);

    import sprite_pkg::*;

    rgb_t       next_color;
    logic [7:0] tail;

    // Six levels 00 to FF in steps of 33
    function automatic logic [7:0] cube_level(input logic [7:0] step);
        return 8'(step * 8'h33);
    endfunction

    assign tail = index - 8'd216;

    always_comb begin
        if (index < 8'd216) begin
            // Red-major 6x6x6 cube
            next_color.r = cube_level(index / 8'd36);
            next_color.g = cube_level((index / 8'd6) % 8'd6);
            next_color.b = cube_level(index % 8'd6);
        end else begin
            next_color.r = tail * 8'h2F;
            next_color.g = tail * 8'h5B;
            next_color.b = tail * 8'h89;
        end
    end

    always_ff @(posedge clk) begin
        color <= next_color;
    end

endmodule

//--- sprite_store.sv
// Module sprite_store, register write decode, object table, background and pattern memory
`timescale 1ns/1ps
`include "sprite_defs.svh"

module sprite_store (
    input  logic               clk,
    input  logic               reset,
    input  logic               chipselect,
    input  logic               write,
    input  logic [`ADDR_W-1:0] address,
    input  logic [31:0]        writedata,
    sprite_bus_if.store        bus
);

    import sprite_pkg::*;

    localparam int PAT_WORDS = `SPRITE_COUNT * `SPRITE_SIZE * `SPRITE_SIZE / 4;

    object_table_t objects;
    rgb_t          background;
    logic [31:0]   pat_mem [PAT_WORDS];
    logic [31:0]   pat_word_q;
    logic [1:0]    lane_q;
    logic [7:0]    pat_idx;
    logic          wr_en;
    logic          pat_sel;

    assign wr_en   = chipselect && write;
    assign pat_sel = address >= `ADDR_W'(`ADDR_PAT_BASE);
    assign pat_idx = 8'(address - `ADDR_W'(`ADDR_PAT_BASE));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            background <= `BG_RESET;
            for (int i = 0; i < `MAX_OBJECTS; i++) begin
                objects[i] <= '0;
            end
        end else if (wr_en) begin
            if (address == `ADDR_W'(`ADDR_BG)) begin
                background <= writedata[23:0];
            end
            for (int i = 0; i < `MAX_OBJECTS; i++) begin
                if (address == `ADDR_W'(`ADDR_OBJ_BASE + i)) begin
                    objects[i].x      <= writedata[31:20];
                    objects[i].y      <= writedata[19:8];
                    objects[i].sprite <= writedata[4:3];
                    objects[i].active <= writedata[2];
                end
            end
        end
    end

    // Four pixels per word, byte k at bits 8k+7..8k
    always_ff @(posedge clk) begin
        if (wr_en && pat_sel) begin
            pat_mem[pat_idx] <= writedata;
        end
        pat_word_q <= pat_mem[bus.pat_addr[9:2]];
        lane_q     <= bus.pat_addr[1:0];
    end

    assign bus.pat_data   = pat_word_q[8*lane_q +: 8];
    assign bus.objects    = objects;
    assign bus.background = background;

endmodule

//--- vga_timing.sv
// Module vga_timing, double-rate scan counters with sync, blank and pixel clock
`timescale 1ns/1ps
`include "sprite_defs.svh"

module vga_timing (
    input  logic   clk,
    input  logic   reset,
    scan_if.source scan
);

    logic [10:0] hcount;
    logic [9:0]  vcount;
    logic        end_of_line;
    logic        end_of_frame;
    logic        in_hsync;
    logic        in_vsync;

    assign end_of_line  = hcount == 11'(`HTOTAL - 1);
    assign end_of_frame = vcount == 10'(`VTOTAL - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 11'd1;
        end
    end

    // Lines advance at the end of each line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vcount <= '0;
        end else if (end_of_line) begin
            if (end_of_frame) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 10'd1;
            end
        end
    end

    assign in_hsync = (hcount >= 11'(`HSYNC_START)) &&
                      (hcount < 11'(`HSYNC_START + `HSYNC_LEN));
    assign in_vsync = (vcount >= 10'(`VSYNC_START)) &&
                      (vcount < 10'(`VSYNC_START + `VSYNC_LEN));

    assign scan.hcount  = hcount;
    assign scan.vcount  = vcount;
    assign scan.hsync   = !in_hsync;
    assign scan.vsync   = !in_vsync;
    assign scan.blank_n = (hcount < 11'(`HACTIVE)) && (vcount < 10'(`VACTIVE));
    // Half-rate pixel clock
    assign scan.pix_clk = hcount[0];

endmodule

//--- vga_ifs.sv
// Interfaces scan_if and sprite_bus_if with their modports
`timescale 1ns/1ps

interface scan_if;

    logic [10:0] hcount;
    logic [9:0]  vcount;
    logic        hsync;
    logic        vsync;
    logic        blank_n;
    logic        pix_clk;

    modport source (
        output hcount, vcount, hsync, vsync, blank_n, pix_clk
    );

    modport sink (
        input hcount, vcount, hsync, vsync, blank_n, pix_clk
    );

endinterface

interface sprite_bus_if;

    import sprite_pkg::*;

    object_table_t objects;
    rgb_t          background;
    pixel_index_t  pat_data;
    // Byte address into pattern memory
    logic [9:0]    pat_addr;

    modport store (
        output objects, background, pat_data,
        input  pat_addr
    );

    modport renderer (
        input  objects, background, pat_data,
        output pat_addr
    );

endinterface

//--- sprite_pkg.sv
// Colour, pixel index, object record and object table types
`include "sprite_defs.svh"

package sprite_pkg;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef logic [7:0] pixel_index_t;

    // Top-left corner in pixel columns and lines
    typedef struct packed {
        logic [11:0]                      x;
        logic [11:0]                      y;
        logic [$clog2(`SPRITE_COUNT)-1:0] sprite;
        logic                             active;
    } object_t;

    typedef object_t object_table_t [`MAX_OBJECTS];

endpackage

//--- sprite_defs.svh
// Object count, sprite geometry, scan timing and register address map
`ifndef SPRITE_DEFS_SVH
`define SPRITE_DEFS_SVH

// Object table and sprite patterns
`define MAX_OBJECTS    8
`define SPRITE_SIZE    16
`define SPRITE_COUNT   4

// Horizontal timing in double-rate counts
`define HTOTAL         1600
`define HACTIVE        1280
`define HSYNC_START    1312
`define HSYNC_LEN      192

// Vertical timing in lines
`define VTOTAL         525
`define VACTIVE        480
`define VSYNC_START    490
`define VSYNC_LEN      2

// Register map, word addresses
`define ADDR_W         9
`define ADDR_BG        0
`define ADDR_OBJ_BASE  1
`define ADDR_PAT_BASE  256

// Dark green
`define BG_RESET       24'h008000

`endif
